/* source/cache_pkg.sv */
package cache_pkg;

    // ------------------------------------------------------------
    // geometry
    // ------------------------------------------------------------
    localparam int word_width      = 16;
    localparam int addr_width      = 16;
    localparam int words_per_block = 8;
    localparam int block_width     = words_per_block * word_width;   // 128
    localparam int num_ways        = 4;
    localparam int index_width     = 4;
    localparam int num_sets        = 1 << index_width;
    localparam int offset_width    = 3;                               // word in block
    localparam int tag_width       = addr_width - index_width - offset_width - 1;
    localparam int bytes_per_block = 2 * words_per_block;
    localparam int wb_depth        = 2;                               // victim fifo entries
    localparam int age_width       = 2;

    typedef logic [1:0] way_t;

    // cpu side request, byte bit of addr always 0
    typedef struct packed {
        logic                  write;
        logic [addr_width-1:0] addr;
        logic [word_width-1:0] wdata;
    } cpu_req_t;

    typedef struct packed {
        logic                  read;
        logic                  write;
        logic [addr_width-1:0] addr;
        logic [7:0]            wdata;
    } mem_req_t;

    // block leaving the array, dirty is only set for a valid line
    typedef struct packed {
        logic                   dirty;
        logic [tag_width-1:0]   tag;
        logic [index_width-1:0] index;
        logic [block_width-1:0] data;
    } victim_t;

    typedef enum logic [2:0] {
        st_idle,
        st_lookup,
        st_evict,
        st_drain,
        st_fill,
        st_install
    } ctrl_state_t;

endpackage

/* source/cache_controller.sv */
module cache_controller (
    input  logic                               clk,
    input  logic                               reset,
    // cpu side
    input  logic                               cpu_valid,
    input  cache_pkg::cpu_req_t                cpu_req,
    output logic                               cpu_stall,
    output logic [cache_pkg::word_width-1:0]   cpu_rdata,
    output logic                               cpu_rdata_valid,
    // data array
    input  logic                               hit,
    input  logic [cache_pkg::word_width-1:0]   rdata,
    input  cache_pkg::victim_t                 victim,
    output logic [cache_pkg::index_width-1:0]  lk_index,
    output logic [cache_pkg::tag_width-1:0]    lk_tag,
    output logic [cache_pkg::offset_width-1:0] lk_offset,
    output logic [cache_pkg::word_width-1:0]   wr_word,
    output logic                               do_write,
    output logic                               do_install,
    // lru, fill and write-back
    output logic                               access,
    output logic                               fill_start,
    output logic [cache_pkg::addr_width-1:0]   fill_addr,
    input  logic                               fill_done,
    output logic                               wb_push,
    input  logic                               wb_empty,
    // memory port
    input  cache_pkg::mem_req_t                fill_mem_req,
    input  cache_pkg::mem_req_t                wb_mem_req,
    output cache_pkg::mem_req_t                mem_req,
    input  logic                               mem_ack,
    output logic                               fill_ack,
    output logic                               wb_ack
);
    import cache_pkg::*;

    ctrl_state_t           state_q;
    ctrl_state_t           state_d;
    cpu_req_t              req_q;      // accepted request
    logic [word_width-1:0] rdata_q;
    logic                  rdata_valid_q;
    logic                  lookup_hit;

    // ------------------------------------------------------------
    // address split as tag | index | word | byte
    // ------------------------------------------------------------
    assign lk_tag    = req_q.addr[addr_width-1 -: tag_width];
    assign lk_index  = req_q.addr[offset_width+1 +: index_width];
    assign lk_offset = req_q.addr[1 +: offset_width];
    assign wr_word   = req_q.wdata;
    assign fill_addr = {lk_tag, lk_index, {(offset_width+1){1'b0}}};

    assign lookup_hit = (state_q == st_lookup) && hit;

    assign access     = lookup_hit;                 // also after install
    assign do_write   = lookup_hit && req_q.write;
    assign do_install = (state_q == st_install);
    assign wb_push    = (state_q == st_evict) && victim.dirty;  // clean victim just dropped
    assign fill_start = (state_q == st_drain) && wb_empty;

    assign cpu_stall       = (state_q != st_idle);
    assign cpu_rdata       = rdata_q;
    assign cpu_rdata_valid = rdata_valid_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            st_idle:    if (cpu_valid) state_d = st_lookup;
            st_lookup:  state_d = hit ? st_idle : st_evict;
            st_evict:   state_d = st_drain;
            st_drain:   if (wb_empty) state_d = st_fill;
            st_fill:    if (fill_done) state_d = st_install;
            st_install: state_d = st_lookup;    // second lookup hits
            default:    state_d = st_idle;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state_q       <= st_idle;
            rdata_valid_q <= 1'b0;
        end else begin
            state_q       <= state_d;
            rdata_valid_q <= lookup_hit && !req_q.write;
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == st_idle && cpu_valid) begin
            req_q <= cpu_req;
        end
        if (lookup_hit && !req_q.write) begin
            rdata_q <= rdata;
        end
    end

    // ------------------------------------------------------------
    // fill owns the memory port only while filling
    // ------------------------------------------------------------
    assign mem_req  = (state_q == st_fill) ? fill_mem_req : wb_mem_req;
    assign fill_ack = mem_ack && (state_q == st_fill);
    assign wb_ack   = mem_ack && (state_q != st_fill);

    // fill read and victim write would meet on the one port
    a_mem_rw_exclusive: assert property (
        @(posedge clk) disable iff (reset) !(fill_mem_req.read && wb_mem_req.write)
    );

endmodule

/* source/cache_data_array.sv */
module cache_data_array (
    input  logic                               clk,
    input  logic                               reset,
    input  logic [cache_pkg::index_width-1:0]  lk_index,
    input  logic [cache_pkg::tag_width-1:0]    lk_tag,
    input  logic [cache_pkg::offset_width-1:0] lk_offset,
    input  logic [cache_pkg::word_width-1:0]   wr_word,
    input  logic                               do_write,
    input  logic                               do_install,
    input  logic [cache_pkg::block_width-1:0]  fill_block,
    input  cache_pkg::way_t                    victim_way,
    output logic                               hit,
    output cache_pkg::way_t                    hit_way,
    output logic [cache_pkg::word_width-1:0]   rdata,
    output cache_pkg::victim_t                 victim
);
    import cache_pkg::*;

    typedef logic [words_per_block-1:0][word_width-1:0] block_t;

    logic [tag_width-1:0] tag_q   [num_sets][num_ways];
    block_t               data_q  [num_sets][num_ways];
    logic [num_ways-1:0]  valid_q [num_sets];
    logic [num_ways-1:0]  dirty_q [num_sets];

    // ------------------------------------------------------------
    // lookup
    // ------------------------------------------------------------
    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = 0; w < num_ways; w++) begin
            if (valid_q[lk_index][w] && tag_q[lk_index][w] == lk_tag) begin
                hit     = 1'b1;
                hit_way = way_t'(w);
            end
        end
    end

    assign rdata = data_q[lk_index][hit_way][lk_offset];

    // victim readout for the lru way
    always_comb begin
        victim.dirty = valid_q[lk_index][victim_way] && dirty_q[lk_index][victim_way];
        victim.tag   = tag_q[lk_index][victim_way];
        victim.index = lk_index;
        victim.data  = data_q[lk_index][victim_way];
    end

    // ------------------------------------------------------------
    // state bits
    // ------------------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int s = 0; s < num_sets; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
            end
        end else if (do_install) begin
            valid_q[lk_index][victim_way] <= 1'b1;
            dirty_q[lk_index][victim_way] <= 1'b0;   // fresh from memory
        end else if (do_write) begin
            dirty_q[lk_index][hit_way] <= 1'b1;
        end
    end

    // tags and block data
    always_ff @(posedge clk) begin
        if (do_install) begin
            tag_q[lk_index][victim_way]  <= lk_tag;
            data_q[lk_index][victim_way] <= fill_block;
        end else if (do_write) begin
            data_q[lk_index][hit_way][lk_offset] <= wr_word;
        end
    end

    // writes come from the controller only on a lookup that hit
    a_write_on_hit: assert property (
        @(posedge clk) disable iff (reset) do_write |-> hit
    );

endmodule

/* source/lru_tracker.sv */
module lru_tracker (
    input  logic                              clk,
    input  logic                              reset,
    input  logic [cache_pkg::index_width-1:0] lk_index,
    input  logic                              access,
    input  cache_pkg::way_t                   hit_way,
    output cache_pkg::way_t                   victim_way
);
    import cache_pkg::*;

    // age 0 is most recent, num_ways-1 is the victim
    logic [age_width-1:0] age_q [num_sets][num_ways];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int s = 0; s < num_sets; s++) begin
                for (int w = 0; w < num_ways; w++) begin
                    age_q[s][w] <= age_width'(w);
                end
            end
        end else if (access) begin
            for (int w = 0; w < num_ways; w++) begin
                if (way_t'(w) == hit_way) begin
                    age_q[lk_index][w] <= '0;
                end else if (age_q[lk_index][w] < age_q[lk_index][hit_way]) begin
                    age_q[lk_index][w] <= age_q[lk_index][w] + 1'b1;
                end
            end
        end
    end

    // ages stay a permutation, so exactly one way is oldest
    always_comb begin
        victim_way = '0;
        for (int w = 0; w < num_ways; w++) begin
            if (age_q[lk_index][w] == age_width'(num_ways - 1)) begin
                victim_way = way_t'(w);
            end
        end
    end

endmodule

/* source/fill_buffer.sv */
module fill_buffer (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              start,
    input  logic [cache_pkg::addr_width-1:0]  base_addr,
    input  logic                              mem_ack,
    input  logic [7:0]                        mem_rdata,
    output cache_pkg::mem_req_t               mem_req,
    output logic                              fill_done,
    output logic [cache_pkg::block_width-1:0] fill_block
);
    import cache_pkg::*;

    localparam int cnt_width = $clog2(bytes_per_block);

    logic                  active_q;
    logic [cnt_width-1:0]  byte_cnt_q;
    logic [addr_width-1:0] base_q;

    always_comb begin
        mem_req       = '0;
        mem_req.read  = active_q;
        mem_req.addr  = base_q + addr_width'(byte_cnt_q);
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            active_q   <= 1'b0;
            byte_cnt_q <= '0;
            fill_done  <= 1'b0;
        end else begin
            fill_done <= 1'b0;
            if (start) begin
                active_q   <= 1'b1;
                byte_cnt_q <= '0;
            end else if (active_q && mem_ack) begin
                byte_cnt_q <= byte_cnt_q + 1'b1;
                if (byte_cnt_q == cnt_width'(bytes_per_block - 1)) begin
                    active_q  <= 1'b0;
                    fill_done <= 1'b1;   // cycle after last ack
                end
            end
        end
    end

    // little endian, byte n lands at bits 8n
    always_ff @(posedge clk) begin
        if (start) begin
            base_q <= base_addr;
        end
        if (active_q && mem_ack) begin
            fill_block[byte_cnt_q*8 +: 8] <= mem_rdata;
        end
    end

    a_no_restart: assert property (
        @(posedge clk) disable iff (reset) start |-> !active_q
    );

endmodule

/* source/write_back_buffer.sv */
module write_back_buffer (
    input  logic                clk,
    input  logic                reset,
    input  logic                push,
    input  cache_pkg::victim_t  victim,
    input  logic                mem_ack,
    output cache_pkg::mem_req_t mem_req,
    output logic                wb_empty
);
    import cache_pkg::*;

    localparam int ptr_width   = (wb_depth > 1) ? $clog2(wb_depth) : 1;
    localparam int count_width = $clog2(wb_depth + 1);
    localparam int cnt_width   = $clog2(bytes_per_block);

    typedef logic [ptr_width-1:0] ptr_t;

    victim_t                entry_q [wb_depth];
    ptr_t                   head_q;            // oldest, being drained
    ptr_t                   tail_q;            // next free slot
    logic [count_width-1:0] count_q;
    logic [cnt_width-1:0]   byte_cnt_q;
    victim_t                head_entry;
    logic                   full;
    logic                   pop;

    function automatic ptr_t next_ptr(input ptr_t p);
        return (p == ptr_t'(wb_depth - 1)) ? '0 : p + 1'b1;
    endfunction

    assign head_entry = entry_q[head_q];
    assign wb_empty   = (count_q == '0);
    assign full       = (count_q == count_width'(wb_depth));
    assign pop        = !wb_empty && mem_ack && (byte_cnt_q == cnt_width'(bytes_per_block - 1));

    // ------------------------------------------------------------
    // drain side, ascending byte addresses
    // ------------------------------------------------------------
    always_comb begin
        mem_req       = '0;
        mem_req.write = !wb_empty;
        mem_req.addr  = {head_entry.tag, head_entry.index, byte_cnt_q};
        mem_req.wdata = head_entry.data[byte_cnt_q*8 +: 8];
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            head_q     <= '0;
            tail_q     <= '0;
            count_q    <= '0;
            byte_cnt_q <= '0;
        end else begin
            if (push) begin
                tail_q <= next_ptr(tail_q);
            end
            if (!wb_empty && mem_ack) begin
                byte_cnt_q <= byte_cnt_q + 1'b1;   // wraps to 0 on pop
            end
            if (pop) begin
                head_q <= next_ptr(head_q);
            end
            if (push && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (pop && !push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            entry_q[tail_q] <= victim;
        end
    end

    a_no_push_full: assert property (
        @(posedge clk) disable iff (reset) push |-> !full
    );

endmodule

/* source/cache_top.sv */
module cache_top (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             cpu_valid,
    input  cache_pkg::cpu_req_t              cpu_req,
    output logic                             cpu_stall,
    output logic [cache_pkg::word_width-1:0] cpu_rdata,
    output logic                             cpu_rdata_valid,
    output cache_pkg::mem_req_t              mem_req,
    input  logic [7:0]                       mem_rdata,
    input  logic                             mem_ack
);
    import cache_pkg::*;

    // controller to array
    logic [index_width-1:0]  lk_index;
    logic [tag_width-1:0]    lk_tag;
    logic [offset_width-1:0] lk_offset;
    logic [word_width-1:0]   wr_word;
    logic                    do_write;
    logic                    do_install;

    // array back to controller
    logic                    hit;
    way_t                    hit_way;
    logic [word_width-1:0]   rdata;
    victim_t                 victim;

    // lru
    logic                    access;
    way_t                    victim_way;

    // fill and write-back paths
    logic                    fill_start;
    logic [addr_width-1:0]   fill_addr;
    logic                    fill_done;
    logic [block_width-1:0]  fill_block;
    logic                    fill_ack;
    mem_req_t                fill_mem_req;
    logic                    wb_push;
    logic                    wb_empty;
    logic                    wb_ack;
    mem_req_t                wb_mem_req;

    cache_controller u_ctrl (.*);

    cache_data_array u_array (.*);

    lru_tracker u_lru (.*);

    fill_buffer u_fill (
        .clk        (clk),
        .reset      (reset),
        .start      (fill_start),
        .base_addr  (fill_addr),
        .mem_ack    (fill_ack),
        .mem_rdata  (mem_rdata),
        .mem_req    (fill_mem_req),
        .fill_done  (fill_done),
        .fill_block (fill_block)
    );

    write_back_buffer u_wb (
        .clk      (clk),
        .reset    (reset),
        .push     (wb_push),
        .victim   (victim),
        .mem_ack  (wb_ack),
        .mem_req  (wb_mem_req),
        .wb_empty (wb_empty)
    );

endmodule

/* sim/mem_model.sv */
module mem_model (
    input  logic                clk,
    input  logic                reset,
    input  cache_pkg::mem_req_t mem_req,
    output logic [7:0]          mem_rdata,
    output logic                mem_ack
);
    timeunit 1ns;
    timeprecision 100ps;

    import cache_pkg::*;

    logic [7:0]  mem [1 << addr_width];
    logic [31:0] lfsr = 32'h4a14;
    logic        busy;
    logic [1:0]  delay;          // cycles left before ack
    int          read_count  = 0;
    int          write_count = 0;

    function automatic logic [31:0] galois_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // one lfsr step per bit taken
    task automatic draw_delay(output logic [1:0] d);
        for (int i = 0; i < 2; i++) begin
            d[i] = lfsr[0];
            lfsr = galois_step(lfsr);
        end
    endtask

    task automatic respond();
        mem_ack <= 1'b1;
        if (mem_req.read) begin
            mem_rdata  <= mem[mem_req.addr];
            read_count <= read_count + 1;
        end else begin
            mem[mem_req.addr] <= mem_req.wdata;
            write_count       <= write_count + 1;
        end
    endtask

    initial begin
        logic [15:0] a;
        mem_ack   = 1'b0;
        mem_rdata = '0;
        for (int i = 0; i < (1 << addr_width); i++) begin
            a      = 16'(i);
            mem[i] = a[7:0] ^ a[15:8];
        end
    end

    always @(posedge clk or posedge reset) begin
        logic [1:0] d;
        if (reset) begin
            mem_ack <= 1'b0;
            busy    <= 1'b0;
            delay   <= '0;
        end else if (mem_ack) begin
            mem_ack <= 1'b0;         // requester moves on at this edge
            busy    <= 1'b0;
        end else if (busy) begin
            if (delay == 2'd0) begin
                respond();
            end else begin
                delay <= delay - 2'd1;
            end
        end else if (mem_req.read || mem_req.write) begin
            draw_delay(d);
            if (d == 2'd0) begin
                respond();
            end else begin
                busy  <= 1'b1;
                delay <= d - 2'd1;
            end
        end
    end

endmodule

/* sim/cache_tb.sv */
module cache_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import cache_pkg::*;

    typedef struct packed {
        logic        write;
        logic [15:0] addr;
        logic [15:0] wdata;
        logic        exp_hit;
    } step_t;

    logic                  clk;
    logic                  reset;
    logic                  cpu_valid;
    cpu_req_t              cpu_req;
    logic                  cpu_stall;
    logic [word_width-1:0] cpu_rdata;
    logic                  cpu_rdata_valid;
    mem_req_t              mem_req;
    logic [7:0]            mem_rdata;
    logic                  mem_ack;
    ctrl_state_t           ctrl_state;          // for the wave viewer

    step_t                 steps [$];
    logic [15:0]           word_image [32768];  // cpu view by word address
    logic [tag_width-1:0]  m_tag   [num_sets][num_ways];
    logic                  m_valid [num_sets][num_ways];
    logic                  m_dirty [num_sets][num_ways];
    logic [age_width-1:0]  m_age   [num_sets][num_ways];
    int                    cycle_count   = 0;
    int                    timeout_limit = 0;

    cache_top u_dut (
        .clk             (clk),
        .reset           (reset),
        .cpu_valid       (cpu_valid),
        .cpu_req         (cpu_req),
        .cpu_stall       (cpu_stall),
        .cpu_rdata       (cpu_rdata),
        .cpu_rdata_valid (cpu_rdata_valid),
        .mem_req         (mem_req),
        .mem_rdata       (mem_rdata),
        .mem_ack         (mem_ack)
    );

    mem_model u_mem (
        .clk       (clk),
        .reset     (reset),
        .mem_req   (mem_req),
        .mem_rdata (mem_rdata),
        .mem_ack   (mem_ack)
    );

    assign ctrl_state = u_dut.u_ctrl.state_q;

    always #20 clk = ~clk;

    // ------------------------------------------------------------
    // failure reporting
    // ------------------------------------------------------------
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1, "stopping at first failure");
    endtask

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected) begin
            abort_run($sformatf("error: %s got 0x%0h expected 0x%0h",
                                name, actual, expected));
        end
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_limit) begin
            abort_run("timeout: access did not complete");
        end
    end

    // ------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------
    function automatic logic [7:0] initial_byte(input logic [15:0] a);
        return a[7:0] ^ a[15:8];
    endfunction

    // accessed way becomes youngest and younger ways age by one
    task automatic lru_touch(input int idx, input int way);
        logic [age_width-1:0] old_age;
        old_age = m_age[idx][way];
        for (int w = 0; w < num_ways; w++) begin
            if (w == way) begin
                m_age[idx][w] = '0;
            end else if (m_age[idx][w] < old_age) begin
                m_age[idx][w] = m_age[idx][w] + 1'b1;
            end
        end
    endtask

    task automatic model_access(input logic [15:0] addr, input logic write,
                                output logic hit, output logic evict_dirty,
                                output logic [15:0] evict_base);
        int                   idx;
        int                   way;
        logic [tag_width-1:0] tag;
        idx         = addr[7:4];
        tag         = addr[15:8];
        hit         = 1'b0;
        way         = 0;
        evict_dirty = 1'b0;
        evict_base  = '0;
        for (int w = 0; w < num_ways; w++) begin
            if (m_valid[idx][w] && m_tag[idx][w] == tag) begin
                hit = 1'b1;
                way = w;
            end
        end
        if (!hit) begin
            for (int w = 0; w < num_ways; w++) begin
                if (m_age[idx][w] == age_width'(num_ways - 1)) begin
                    way = w;                 // oldest way goes
                end
            end
            evict_dirty        = m_valid[idx][way] && m_dirty[idx][way];
            evict_base         = {m_tag[idx][way], addr[7:4], 4'h0};
            m_valid[idx][way]  = 1'b1;
            m_tag[idx][way]    = tag;
            m_dirty[idx][way]  = 1'b0;
        end
        lru_touch(idx, way);
        if (write) begin
            m_dirty[idx][way] = 1'b1;
        end
    endtask

    // memory must hold the cpu view of a block after write-back
    task automatic check_written_block(input logic [15:0] base);
        logic [15:0] a;
        logic [15:0] w;
        for (int i = 0; i < words_per_block; i++) begin
            a = base + 16'(2 * i);
            w = word_image[a[15:1]];
            check("mem write low byte", u_mem.mem[a], w[7:0]);
            check("mem write high byte", u_mem.mem[a + 16'd1], w[15:8]);
        end
    endtask

    // ------------------------------------------------------------
    // stimulus table
    // ------------------------------------------------------------
    task automatic add_step(input logic write, input logic [15:0] addr,
                            input logic [15:0] wdata, input logic exp_hit);
        step_t s;
        s.write   = write;
        s.addr    = addr;
        s.wdata   = wdata;
        s.exp_hit = exp_hit;
        steps.push_back(s);
    endtask

    task automatic load_table();
        add_step(1'b0, 16'h1234, 16'h0000, 1'b0);   // cold miss in set 3
        add_step(1'b0, 16'h1236, 16'h0000, 1'b1);
        add_step(1'b1, 16'h1234, 16'hbeef, 1'b1);
        add_step(1'b0, 16'h1234, 16'h0000, 1'b1);
        add_step(1'b1, 16'h5678, 16'h1357, 1'b0);   // write allocate
        add_step(1'b0, 16'h5678, 16'h0000, 1'b1);
        // five tags in set 5
        add_step(1'b0, 16'ha050, 16'h0000, 1'b0);
        add_step(1'b1, 16'ha152, 16'h1111, 1'b0);
        add_step(1'b0, 16'ha254, 16'h0000, 1'b0);
        add_step(1'b0, 16'ha356, 16'h0000, 1'b0);
        add_step(1'b0, 16'ha050, 16'h0000, 1'b1);   // re-touch a0
        add_step(1'b0, 16'ha458, 16'h0000, 1'b0);   // dirty a1 leaves
        add_step(1'b0, 16'ha152, 16'h0000, 1'b0);
        add_step(1'b0, 16'ha254, 16'h0000, 1'b0);
        add_step(1'b1, 16'ha05e, 16'h2222, 1'b1);
        add_step(1'b0, 16'ha35a, 16'h0000, 1'b0);
        add_step(1'b0, 16'ha05e, 16'h0000, 1'b1);
        // set 15
        add_step(1'b1, 16'h00f0, 16'hcafe, 1'b0);
        add_step(1'b0, 16'h00f0, 16'h0000, 1'b1);
        add_step(1'b0, 16'hfffe, 16'h0000, 1'b0);
        // push the dirty 0x56 block out of set 7, then read it back
        add_step(1'b0, 16'h5770, 16'h0000, 1'b0);
        add_step(1'b0, 16'h5872, 16'h0000, 1'b0);
        add_step(1'b0, 16'h5974, 16'h0000, 1'b0);
        add_step(1'b0, 16'h5a76, 16'h0000, 1'b0);
        add_step(1'b0, 16'h5678, 16'h0000, 1'b0);
        add_step(1'b0, 16'h5a76, 16'h0000, 1'b1);
    endtask

    task automatic run_step(input step_t s);
        logic        model_hit;
        logic        evict_dirty;
        logic [15:0] evict_base;
        logic [15:0] expected;
        int          reads_before;
        int          writes_before;
        int          latency;
        logic        done;

        model_access(s.addr, s.write, model_hit, evict_dirty, evict_base);
        check("model hit", model_hit, s.exp_hit);
        expected      = word_image[s.addr[15:1]];
        reads_before  = u_mem.read_count;
        writes_before = u_mem.write_count;

        @(posedge clk);
        cpu_valid <= 1'b1;
        cpu_req   <= {s.write, s.addr, s.wdata};
        @(negedge clk);
        while (cpu_stall) begin
            @(negedge clk);
        end
        @(posedge clk);                          // accept edge
        cpu_valid <= 1'b0;

        latency = 0;
        done    = 1'b0;
        while (!done) begin
            @(negedge clk);
            latency++;
            done = s.write ? !cpu_stall : cpu_rdata_valid;
        end

        if (!s.write) begin
            check("cpu_rdata", cpu_rdata, expected);
            check("cpu_stall", cpu_stall, 1'b0);
        end else begin
            check("cpu_rdata_valid", cpu_rdata_valid, 1'b0);   // writes return no data
            word_image[s.addr[15:1]] = s.wdata;
        end
        if (s.exp_hit) begin
            check("hit latency", latency, 2);
        end
        check("mem read count", u_mem.read_count - reads_before,
              s.exp_hit ? 0 : bytes_per_block);
        check("mem write count", u_mem.write_count - writes_before,
              evict_dirty ? bytes_per_block : 0);
        if (evict_dirty) begin
            check_written_block(evict_base);
        end
        if (!s.write) begin
            @(negedge clk);
            check("cpu_rdata_valid", cpu_rdata_valid, 1'b0);   // one cycle pulse
        end
    endtask

    // ------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------
    initial begin
        logic [15:0] a;
        clk       = 1'b0;
        reset     = 1'b1;
        cpu_valid = 1'b0;
        cpu_req   = '0;
        for (int i = 0; i < 32768; i++) begin
            a             = 16'(2 * i);
            word_image[i] = {initial_byte(a + 16'd1), initial_byte(a)};
        end
        for (int s = 0; s < num_sets; s++) begin
            for (int w = 0; w < num_ways; w++) begin
                m_valid[s][w] = 1'b0;
                m_dirty[s][w] = 1'b0;
                m_tag[s][w]   = '0;
                m_age[s][w]   = age_width'(w);
            end
        end
        load_table();
        timeout_limit = steps.size() * 200 + 100;

        repeat (16) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check("cpu_stall", cpu_stall, 1'b0);
        check("cpu_rdata_valid", cpu_rdata_valid, 1'b0);
        check("mem_req.read", mem_req.read, 1'b0);
        check("mem_req.write", mem_req.write, 1'b0);

        foreach (steps[i]) begin
            run_step(steps[i]);
        end

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

/* project.f */
source/cache_pkg.sv
source/cache_controller.sv
source/cache_data_array.sv
source/lru_tracker.sv
source/fill_buffer.sv
source/write_back_buffer.sv
source/cache_top.sv
sim/mem_model.sv
sim/cache_tb.sv
